// ==== pwrmgr_pkg.sv ====
////////////////////////////////////////
// Shared types for the power manager
// AST response is asynchronous and must be synced before use
// clk_val is one bit that covers both core and io clocks
////////////////////////////////////////
package pwrmgr_pkg;

  // Reason for the last power-up
  typedef enum logic {
    Por    = 1'b0,
    Wakeup = 1'b1
  } pwrup_cause_e;

  // Slow domain sequencing states
  typedef enum logic [2:0] {
    SlowActive   = 3'd0,
    SlowClkOff   = 3'd1,
    SlowPwrOff   = 3'd2,
    SlowLowPower = 3'd3,
    SlowPwrOn    = 3'd4,
    SlowClkOn    = 3'd5,
    SlowReqPwrup = 3'd6
  } slow_state_e;

  // Request from the slow domain to the analog block
  typedef struct packed {
    logic main_pd_n;
    logic core_clk_en;
    logic io_clk_en;
  } pwr_ast_req_t;

  // Status from the analog block, unknown domain
  typedef struct packed {
    logic main_pok;
    logic clk_val;
  } pwr_ast_rsp_t;

  // What stays powered or clocked in low power
  typedef struct packed {
    logic main_pd_n;
    logic core_clk_en;
    logic io_clk_en;
  } pwr_lp_cfg_t;

  // Reset values
  localparam pwr_ast_rsp_t pwr_ast_rsp_default = '{main_pok: 1'b1, clk_val: 1'b1};
  localparam pwr_ast_req_t pwr_ast_req_default = '{
    main_pd_n:   1'b1,
    core_clk_en: 1'b1,
    io_clk_en:   1'b1
  };
  localparam pwr_lp_cfg_t pwr_lp_cfg_default = '{
    main_pd_n:   1'b1,
    core_clk_en: 1'b1,
    io_clk_en:   1'b1
  };

endpackage

// ==== pwrmgr_pulse_sync.sv ====
////////////////////////////////////////
// Single pulse crossing by toggle
// Source pulses need a gap until the previous one has arrived
////////////////////////////////////////
`timescale 1ns/1ns

module pwrmgr_pulse_sync (
  input  logic clk_src_i,
  input  logic rst_src_ni,
  input  logic src_pulse_i,
  input  logic clk_dst_i,
  input  logic rst_dst_ni,
  output logic dst_pulse_o
);

  // Source toggle
  logic src_toggle_q;
  // Destination sync chain and edge detect stage
  logic dst_sync1_q;
  logic dst_sync2_q;
  logic dst_level_q;

  // Each source pulse flips the level
  always_ff @(posedge clk_src_i or negedge rst_src_ni) begin
    if (!rst_src_ni) begin
      src_toggle_q <= 1'b0;
    end else if (src_pulse_i) begin
      src_toggle_q <= ~src_toggle_q;
    end
  end

  // Two flops into the destination, then one more to find the edge
  always_ff @(posedge clk_dst_i or negedge rst_dst_ni) begin
    if (!rst_dst_ni) begin
      dst_sync1_q <= 1'b0;
      dst_sync2_q <= 1'b0;
      dst_level_q <= 1'b0;
    end else begin
      dst_sync1_q <= src_toggle_q;
      dst_sync2_q <= dst_sync1_q;
      dst_level_q <= dst_sync2_q;
    end
  end

  // Either edge of the toggle gives one destination cycle
  assign dst_pulse_o = dst_sync2_q ^ dst_level_q;

  // New pulse only once the destination has taken the last toggle
  pulse_spacing_a : assert property (@(posedge clk_src_i) disable iff (!rst_src_ni)
    src_pulse_i |-> (src_toggle_q == dst_level_q));

endmodule

// ==== pwrmgr_cdc.sv ====
////////////////////////////////////////
// Crossings between fast and slow domains
// Fast config must hold steady until cdc_sync_done_o returns
// AST status is taken only when two sync stages agree
////////////////////////////////////////
`timescale 1ns/1ns

module pwrmgr_cdc #(
  parameter int NumWkups = 4
) (
  // Clocks and resets
  input  logic                       clk_slow_i,
  input  logic                       rst_slow_ni,
  input  logic                       clk_fast_i,
  input  logic                       rst_fast_ni,

  // Fast side inputs
  input  logic                       req_pwrdn_i,
  input  logic                       ack_pwrup_i,
  input  logic                       cfg_cdc_sync_i,
  input  logic [NumWkups-1:0]        wakeup_en_i,
  input  pwrmgr_pkg::pwr_lp_cfg_t    lp_cfg_i,

  // Toward the slow domain
  output logic                       slow_req_pwrdn_o,
  output logic                       slow_ack_pwrup_o,
  output logic [NumWkups-1:0]        slow_wakeup_en_o,
  output pwrmgr_pkg::pwr_lp_cfg_t    slow_lp_cfg_o,
  output pwrmgr_pkg::pwr_ast_rsp_t   slow_ast_o,

  // From the slow domain
  input  logic                       slow_ack_pwrdn_i,
  input  logic                       slow_req_pwrup_i,
  input  logic                       slow_cause_toggle_i,
  input  pwrmgr_pkg::pwrup_cause_e   slow_pwrup_cause_i,
  input  logic [NumWkups-1:0]        slow_wake_status_i,

  // AST status, any domain
  input  pwrmgr_pkg::pwr_ast_rsp_t   ast_i,

  // Fast side outputs
  output logic                       ack_pwrdn_o,
  output logic                       req_pwrup_o,
  output logic                       cdc_sync_done_o,
  output pwrmgr_pkg::pwrup_cause_e   pwrup_cause_o,
  output logic [NumWkups-1:0]        wake_status_o
);

  import pwrmgr_pkg::*;

  ////////////////////////////////////////
  // Fast to slow
  ////////////////////////////////////////

  // Handshake levels, bit 1 req_pwrdn, bit 0 ack_pwrup
  logic [1:0]   slow_lvl_s1_q;
  logic [1:0]   slow_lvl_s2_q;
  // Config load strobe in slow domain
  logic         slow_cdc_sync;
  // AST sync chain plus agreement stage
  pwr_ast_rsp_t slow_ast_s1_q;
  pwr_ast_rsp_t slow_ast_s2_q;
  pwr_ast_rsp_t slow_ast_s3_q;

  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      slow_lvl_s1_q <= 2'b00;
      slow_lvl_s2_q <= 2'b00;
    end else begin
      slow_lvl_s1_q <= {req_pwrdn_i, ack_pwrup_i};
      slow_lvl_s2_q <= slow_lvl_s1_q;
    end
  end

  assign slow_req_pwrdn_o = slow_lvl_s2_q[1];
  assign slow_ack_pwrup_o = slow_lvl_s2_q[0];

  // Config request pulse
  pwrmgr_pulse_sync u_cfg_sync (
    .clk_src_i   (clk_fast_i),
    .rst_src_ni  (rst_fast_ni),
    .src_pulse_i (cfg_cdc_sync_i),
    .clk_dst_i   (clk_slow_i),
    .rst_dst_ni  (rst_slow_ni),
    .dst_pulse_o (slow_cdc_sync)
  );

  // Fast config is quiet here, so a plain load is safe
  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      slow_wakeup_en_o <= '0;
      slow_lp_cfg_o    <= pwr_lp_cfg_default;
    end else if (slow_cdc_sync) begin
      slow_wakeup_en_o <= wakeup_en_i;
      slow_lp_cfg_o    <= lp_cfg_i;
    end
  end

  // AST status
  // Two flops, then one delay stage for the compare
  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      slow_ast_s1_q <= pwr_ast_rsp_default;
      slow_ast_s2_q <= pwr_ast_rsp_default;
      slow_ast_s3_q <= pwr_ast_rsp_default;
    end else begin
      slow_ast_s1_q <= ast_i;
      slow_ast_s2_q <= slow_ast_s1_q;
      slow_ast_s3_q <= slow_ast_s2_q;
    end
  end

  // Hold old value while bits are still settling
  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      slow_ast_o <= pwr_ast_rsp_default;
    end else if (slow_ast_s3_q == slow_ast_s2_q) begin
      slow_ast_o <= slow_ast_s3_q;
    end
  end

  ////////////////////////////////////////
  // Slow to fast
  ////////////////////////////////////////

  // Bit 2 ack_pwrdn, bit 1 req_pwrup, bit 0 cause toggle
  logic [2:0] fast_lvl_s1_q;
  logic [2:0] fast_lvl_s2_q;
  // Previous toggle for change detect
  logic       fast_toggle_q;
  logic       cause_chg;

  always_ff @(posedge clk_fast_i or negedge rst_fast_ni) begin
    if (!rst_fast_ni) begin
      fast_lvl_s1_q <= 3'b000;
      fast_lvl_s2_q <= 3'b000;
      fast_toggle_q <= 1'b0;
    end else begin
      fast_lvl_s1_q <= {slow_ack_pwrdn_i, slow_req_pwrup_i, slow_cause_toggle_i};
      fast_lvl_s2_q <= fast_lvl_s1_q;
      fast_toggle_q <= fast_lvl_s2_q[0];
    end
  end

  assign ack_pwrdn_o = fast_lvl_s2_q[2];
  assign req_pwrup_o = fast_lvl_s2_q[1];
  assign cause_chg   = fast_lvl_s2_q[0] ^ fast_toggle_q;

  // Slow values were written with the toggle and are stable now
  always_ff @(posedge clk_fast_i or negedge rst_fast_ni) begin
    if (!rst_fast_ni) begin
      pwrup_cause_o <= Por;
      wake_status_o <= '0;
    end else if (cause_chg) begin
      pwrup_cause_o <= slow_pwrup_cause_i;
      wake_status_o <= slow_wake_status_i;
    end
  end

  // Config done pulse back to the fast side
  pwrmgr_pulse_sync u_done_sync (
    .clk_src_i   (clk_slow_i),
    .rst_src_ni  (rst_slow_ni),
    .src_pulse_i (slow_cdc_sync),
    .clk_dst_i   (clk_fast_i),
    .rst_dst_ni  (rst_fast_ni),
    .dst_pulse_o (cdc_sync_done_o)
  );

endmodule

// ==== pwrmgr_wake_chan.sv ====
////////////////////////////////////////
// One wakeup channel in the slow domain
// Source must stay high FiltCycles synced samples to count
// Capture is sticky until clr_i
////////////////////////////////////////
`timescale 1ns/1ns

module pwrmgr_wake_chan #(
  parameter int FiltCycles = 4
) (
  input  logic clk_slow_i,
  input  logic rst_slow_ni,
  input  logic wakeup_i,
  input  logic en_i,
  input  logic clr_i,
  output logic captured_o
);

  // Counter wide enough to reach FiltCycles
  localparam int CntW = $clog2(FiltCycles + 1);

  logic            wake_s1_q;
  logic            wake_s2_q;
  logic [CntW-1:0] cnt_q;
  logic            stable;
  logic            captured_q;

  // Raw input is asynchronous
  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      wake_s1_q <= 1'b0;
      wake_s2_q <= 1'b0;
    end else begin
      wake_s1_q <= wakeup_i;
      wake_s2_q <= wake_s1_q;
    end
  end

  // Consecutive high samples, saturating
  // Any low sample starts over
  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      cnt_q <= '0;
    end else if (!wake_s2_q) begin
      cnt_q <= '0;
    end else if (!stable) begin
      cnt_q <= cnt_q + CntW'(1);
    end
  end

  assign stable = (cnt_q == CntW'(FiltCycles));

  // Clear wins over a new capture
  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      captured_q <= 1'b0;
    end else if (clr_i) begin
      captured_q <= 1'b0;
    end else if (stable && en_i) begin
      captured_q <= 1'b1;
    end
  end

  assign captured_o = captured_q;

  // Capture needs an enabled source that ran through the whole filter
  en_mask_a : assert property (@(posedge clk_slow_i) disable iff (!rst_slow_ni)
    $rose(captured_o) |-> $past(en_i) && $past(wake_s2_q, FiltCycles + 1));

endmodule

// ==== pwrmgr_slow_fsm.sv ====
////////////////////////////////////////
// Slow domain power sequencing
// Waits without limit on handshakes and AST status
// ast_i is the synced copy from the CDC block
////////////////////////////////////////
`timescale 1ns/1ns

module pwrmgr_slow_fsm #(
  parameter int NumWkups = 4
) (
  input  logic                     clk_slow_i,
  input  logic                     rst_slow_ni,
  // Synced fast side levels
  input  logic                     req_pwrdn_i,
  input  logic                     ack_pwrup_i,
  input  pwrmgr_pkg::pwr_lp_cfg_t  lp_cfg_i,
  input  pwrmgr_pkg::pwr_ast_rsp_t ast_i,
  // Channel captures
  input  logic [NumWkups-1:0]      captured_i,
  output logic                     ack_pwrdn_o,
  output logic                     req_pwrup_o,
  output logic                     cause_toggle_o,
  output pwrmgr_pkg::pwrup_cause_e pwrup_cause_o,
  output logic [NumWkups-1:0]      wake_status_o,
  output logic                     wake_clr_o,
  output pwrmgr_pkg::pwr_ast_req_t ast_o
);

  import pwrmgr_pkg::*;

  slow_state_e         state_q;
  slow_state_e         state_d;
  pwr_ast_req_t        ast_q;
  pwr_ast_req_t        ast_d;
  pwrup_cause_e        cause_q;
  pwrup_cause_e        cause_d;
  logic [NumWkups-1:0] status_q;
  logic [NumWkups-1:0] status_d;
  logic                toggle_q;
  logic                toggle_d;
  logic                clr_q;
  logic                clr_d;
  logic                ack_pwrdn_q;
  logic                req_pwrup_q;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    ast_d    = ast_q;
    cause_d  = cause_q;
    status_d = status_q;
    toggle_d = toggle_q;
    clr_d    = 1'b0;

    case (state_q)
      // Power-down only while no power-up is still acknowledged
      SlowActive: begin
        if (req_pwrdn_i && !ack_pwrup_i) begin
          state_d = SlowClkOff;
        end
      end

      // Clocks first
      SlowClkOff: begin
        ast_d.core_clk_en = lp_cfg_i.core_clk_en;
        ast_d.io_clk_en   = lp_cfg_i.io_clk_en;
        state_d           = SlowPwrOff;
      end

      // Then main power
      SlowPwrOff: begin
        ast_d.main_pd_n = lp_cfg_i.main_pd_n;
        state_d         = SlowLowPower;
      end

      // Any captured channel wakes; record why
      SlowLowPower: begin
        if (|captured_i) begin
          status_d = captured_i;
          cause_d  = Wakeup;
          toggle_d = ~toggle_q;
          state_d  = SlowPwrOn;
        end
      end

      // Power back on, wait for good status
      SlowPwrOn: begin
        ast_d.main_pd_n = 1'b1;
        if (ast_i.main_pok) begin
          state_d = SlowClkOn;
        end
      end

      // Clocks back on, wait for them to run
      SlowClkOn: begin
        ast_d.core_clk_en = 1'b1;
        ast_d.io_clk_en   = 1'b1;
        if (ast_i.clk_val) begin
          state_d = SlowReqPwrup;
        end
      end

      // Hand over to the fast side
      // Channels are cleared on the way out
      SlowReqPwrup: begin
        if (ack_pwrup_i) begin
          clr_d   = 1'b1;
          state_d = SlowActive;
        end
      end

      default: begin
        state_d = SlowActive;
      end
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  // Handshake levels registered so they cross without glitches
  always_ff @(posedge clk_slow_i or negedge rst_slow_ni) begin
    if (!rst_slow_ni) begin
      state_q     <= SlowActive;
      ast_q       <= pwr_ast_req_default;
      cause_q     <= Por;
      status_q    <= '0;
      toggle_q    <= 1'b0;
      clr_q       <= 1'b0;
      ack_pwrdn_q <= 1'b0;
      req_pwrup_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      ast_q       <= ast_d;
      cause_q     <= cause_d;
      status_q    <= status_d;
      toggle_q    <= toggle_d;
      clr_q       <= clr_d;
      ack_pwrdn_q <= (state_d == SlowLowPower);
      req_pwrup_q <= (state_d == SlowReqPwrup);
    end
  end

  assign ast_o          = ast_q;
  assign ack_pwrdn_o    = ack_pwrdn_q;
  assign req_pwrup_o    = req_pwrup_q;
  assign cause_toggle_o = toggle_q;
  assign pwrup_cause_o  = cause_q;
  assign wake_status_o  = status_q;
  assign wake_clr_o     = clr_q;

  // The two handshakes never overlap
  hs_excl_a : assert property (@(posedge clk_slow_i) disable iff (!rst_slow_ni)
    !(ack_pwrdn_o && ack_pwrup_i) && !(req_pwrup_o && req_pwrdn_i));

endmodule

// ==== pwrmgr_top.sv ====
////////////////////////////////////////
// Power manager top level
// Fast side state machine sits outside this block
////////////////////////////////////////
`timescale 1ns/1ns

module pwrmgr_top #(
  parameter int NumWkups   = 4,
  parameter int FiltCycles = 4
) (
  input  logic                     clk_slow_i,
  input  logic                     rst_slow_ni,
  input  logic                     clk_fast_i,
  input  logic                     rst_fast_ni,
  // Raw wakeups, asynchronous
  input  logic [NumWkups-1:0]      wakeup_i,
  // Fast side config and handshake
  input  logic [NumWkups-1:0]      wakeup_en_i,
  input  pwrmgr_pkg::pwr_lp_cfg_t  lp_cfg_i,
  input  logic                     cfg_cdc_sync_i,
  input  logic                     req_pwrdn_i,
  input  logic                     ack_pwrup_i,
  // Analog block
  input  pwrmgr_pkg::pwr_ast_rsp_t ast_i,
  output pwrmgr_pkg::pwr_ast_req_t ast_o,
  // Back to the fast side
  output logic                     ack_pwrdn_o,
  output logic                     req_pwrup_o,
  output logic                     cdc_sync_done_o,
  output pwrmgr_pkg::pwrup_cause_e pwrup_cause_o,
  output logic [NumWkups-1:0]      wake_status_o
);

  import pwrmgr_pkg::*;

  // Slow domain nets
  logic                slow_req_pwrdn;
  logic                slow_ack_pwrup;
  logic [NumWkups-1:0] slow_wakeup_en;
  pwr_lp_cfg_t         slow_lp_cfg;
  pwr_ast_rsp_t        slow_ast;
  logic                slow_ack_pwrdn;
  logic                slow_req_pwrup;
  logic                slow_cause_toggle;
  pwrup_cause_e        slow_pwrup_cause;
  logic [NumWkups-1:0] slow_wake_status;
  logic [NumWkups-1:0] captured;
  logic                wake_clr;

  pwrmgr_cdc #(
    .NumWkups (NumWkups)
  ) u_cdc (
    .clk_slow_i,
    .rst_slow_ni,
    .clk_fast_i,
    .rst_fast_ni,
    .req_pwrdn_i,
    .ack_pwrup_i,
    .cfg_cdc_sync_i,
    .wakeup_en_i,
    .lp_cfg_i,
    .slow_req_pwrdn_o    (slow_req_pwrdn),
    .slow_ack_pwrup_o    (slow_ack_pwrup),
    .slow_wakeup_en_o    (slow_wakeup_en),
    .slow_lp_cfg_o       (slow_lp_cfg),
    .slow_ast_o          (slow_ast),
    .slow_ack_pwrdn_i    (slow_ack_pwrdn),
    .slow_req_pwrup_i    (slow_req_pwrup),
    .slow_cause_toggle_i (slow_cause_toggle),
    .slow_pwrup_cause_i  (slow_pwrup_cause),
    .slow_wake_status_i  (slow_wake_status),
    .ast_i,
    .ack_pwrdn_o,
    .req_pwrup_o,
    .cdc_sync_done_o,
    .pwrup_cause_o,
    .wake_status_o
  );

  // One channel per wakeup source
  for (genvar i = 0; i < NumWkups; i++) begin : gen_wake_chan
    pwrmgr_wake_chan #(
      .FiltCycles (FiltCycles)
    ) u_wake_chan (
      .clk_slow_i,
      .rst_slow_ni,
      .wakeup_i   (wakeup_i[i]),
      .en_i       (slow_wakeup_en[i]),
      .clr_i      (wake_clr),
      .captured_o (captured[i])
    );
  end

  pwrmgr_slow_fsm #(
    .NumWkups (NumWkups)
  ) u_slow_fsm (
    .clk_slow_i,
    .rst_slow_ni,
    .req_pwrdn_i    (slow_req_pwrdn),
    .ack_pwrup_i    (slow_ack_pwrup),
    .lp_cfg_i       (slow_lp_cfg),
    .ast_i          (slow_ast),
    .captured_i     (captured),
    .ack_pwrdn_o    (slow_ack_pwrdn),
    .req_pwrup_o    (slow_req_pwrup),
    .cause_toggle_o (slow_cause_toggle),
    .pwrup_cause_o  (slow_pwrup_cause),
    .wake_status_o  (slow_wake_status),
    .wake_clr_o     (wake_clr),
    .ast_o
  );

endmodule

// ==== tb_pwrmgr.sv ====
////////////////////////////////////////
// Testbench for the power manager
// Plays the fast side FSM and the AST, random stimulus from a fixed seed
// Fast clock is 1 ns high and 2 ns low, so it has a 3 ns period
////////////////////////////////////////
`timescale 1ns/1ns

module tb_pwrmgr;

  import pwrmgr_pkg::*;

  localparam int NumWkups     = 4;
  localparam int FiltCycles   = 4;
  localparam int Seed         = 40;
  // Limits in fast cycles
  localparam int WaitTimeout  = 400;
  localparam int SyncTimeout  = 100;
  localparam int SettleFast   = 30;
  // Limits in slow cycles
  localparam int GlitchWindow = 40;
  localparam int NumCfgWrites = 5;
  localparam int NumCycles    = 4;
  // Which fast output a wait watches
  localparam int SelAckPwrdn  = 0;
  localparam int SelReqPwrup  = 1;

  logic                clk_slow_i = 1'b0;
  logic                clk_fast_i = 1'b0;
  logic                rst_slow_ni;
  logic                rst_fast_ni;
  logic [NumWkups-1:0] wakeup_i;
  logic [NumWkups-1:0] wakeup_en_i;
  pwr_lp_cfg_t         lp_cfg_i;
  logic                cfg_cdc_sync_i;
  logic                req_pwrdn_i;
  logic                ack_pwrup_i;
  pwr_ast_rsp_t        ast_i = pwr_ast_rsp_default;
  pwr_ast_req_t        ast_o;
  logic                ack_pwrdn_o;
  logic                req_pwrup_o;
  logic                cdc_sync_done_o;
  pwrup_cause_e        pwrup_cause_o;
  logic [NumWkups-1:0] wake_status_o;

  // Reference model state
  logic [NumWkups-1:0] exp_en;
  pwr_lp_cfg_t         exp_lp;
  pwrup_cause_e        exp_cause;
  logic [NumWkups-1:0] exp_status;

  // Bookkeeping
  int errors;
  int checks;
  int tests;
  int failed;
  int test_errs;
  bit timed_out;
  // Owned by the fast side monitor
  int gate_errors;
  int gate_checks;
  int req_rises;
  logic req_prev = 1'b0;
  // AST model countdowns, zero when settled
  int pok_wait = 0;
  int clk_wait = 0;

  pwrmgr_top #(
    .NumWkups   (NumWkups),
    .FiltCycles (FiltCycles)
  ) UUT (
    .clk_slow_i,
    .rst_slow_ni,
    .clk_fast_i,
    .rst_fast_ni,
    .wakeup_i,
    .wakeup_en_i,
    .lp_cfg_i,
    .cfg_cdc_sync_i,
    .req_pwrdn_i,
    .ack_pwrup_i,
    .ast_i,
    .ast_o,
    .ack_pwrdn_o,
    .req_pwrup_o,
    .cdc_sync_done_o,
    .pwrup_cause_o,
    .wake_status_o
  );

  always #4 clk_slow_i = ~clk_slow_i;

  always begin
    #2 clk_fast_i = 1'b1;
    #1 clk_fast_i = 1'b0;
  end

  ////////////////////////////////////////
  // AST model
  ////////////////////////////////////////

  function automatic int rand_delay();
    return 2 + int'($urandom % 8);
  endfunction

  // Status follows the request after a random delay
  // A request that flips back before the delay ends cancels it
  always @(posedge clk_slow_i) begin
    #1;
    if (ast_o.main_pd_n == ast_i.main_pok) begin
      pok_wait = 0;
    end else if (pok_wait == 0) begin
      pok_wait = rand_delay();
    end else begin
      pok_wait--;
      if (pok_wait == 0) begin
        ast_i.main_pok = ast_o.main_pd_n;
      end
    end
    // clk_val covers both clocks
    if ((ast_o.core_clk_en & ast_o.io_clk_en) == ast_i.clk_val) begin
      clk_wait = 0;
    end else if (clk_wait == 0) begin
      clk_wait = rand_delay();
    end else begin
      clk_wait--;
      if (clk_wait == 0) begin
        ast_i.clk_val = ast_o.core_clk_en & ast_o.io_clk_en;
      end
    end
  end

  // Power-up request only once the AST reports good
  always @(posedge clk_fast_i) begin
    if (req_pwrup_o && !req_prev) begin
      req_rises++;
      gate_checks++;
      assert (ast_i.main_pok && ast_i.clk_val) else begin
        $display("req_pwrup_o rose before the AST model reported main_pok and clk_val high");
        gate_errors++;
      end
    end
    req_prev = req_pwrup_o;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic int total_errors();
    return errors + gate_errors;
  endfunction

  task automatic slow_cycles(input int n);
    repeat (n) @(posedge clk_slow_i);
    #1;
  endtask

  task automatic fast_cycles(input int n);
    repeat (n) @(posedge clk_fast_i);
    #1;
  endtask

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic fast_flag(input int sel);
    if (sel == SelAckPwrdn) begin
      return ack_pwrdn_o;
    end
    return req_pwrup_o;
  endfunction

  // Poll a fast output once per fast cycle
  task automatic wait_fast(input int sel, input logic val, input string what);
    int cycles;
    cycles = 0;
    while (fast_flag(sel) !== val && cycles < WaitTimeout) begin
      fast_cycles(1);
      cycles++;
    end
    if (fast_flag(sel) !== val) begin
      $display("timed out waiting for %s", what);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  function automatic logic [NumWkups-1:0] rand_en();
    logic [NumWkups-1:0] en;
    en = NumWkups'($urandom);
    if (en == '0) begin
      en = NumWkups'(1);
    end
    return en;
  endfunction

  function automatic pwr_lp_cfg_t rand_lp();
    return pwr_lp_cfg_t'(3'($urandom));
  endfunction

  // At least one held source must be enabled
  function automatic logic [NumWkups-1:0] pick_held(input logic [NumWkups-1:0] en);
    logic [NumWkups-1:0] held;
    held = NumWkups'($urandom);
    if ((held & en) == '0) begin
      held = held | (en & (~en + NumWkups'(1)));
    end
    return held;
  endfunction

  task automatic start_test();
    test_errs = total_errors();
  endtask

  task automatic finish_test(input string name);
    int n;
    n = total_errors() - test_errs;
    tests++;
    if (n != 0) begin
      failed++;
      $display("test %s: failed with %0d errors", name, n);
    end else if (timed_out) begin
      $display("test %s: skipped after a timeout", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  ////////////////////////////////////////
  // Fast side sequences
  ////////////////////////////////////////

  // Config held until done returns, then exactly one done pulse
  task automatic write_config(input logic [NumWkups-1:0] en, input pwr_lp_cfg_t lp);
    int cycles;
    int pulses;
    if (timed_out) return;
    fast_cycles(1);
    wakeup_en_i    = en;
    lp_cfg_i       = lp;
    cfg_cdc_sync_i = 1'b1;
    fast_cycles(1);
    cfg_cdc_sync_i = 1'b0;
    exp_en = en;
    exp_lp = lp;
    cycles = 0;
    while (!cdc_sync_done_o && cycles < SyncTimeout) begin
      fast_cycles(1);
      cycles++;
    end
    if (!cdc_sync_done_o) begin
      $display("timed out waiting for cdc_sync_done_o");
      errors++;
      timed_out = 1'b1;
      return;
    end
    pulses = 1;
    repeat (SettleFast) begin
      fast_cycles(1);
      if (cdc_sync_done_o) pulses++;
    end
    compare_val("cdc_sync_done_o pulses", 32'(pulses), 32'd1);
  endtask

  task automatic power_down();
    if (timed_out) return;
    fast_cycles(1);
    req_pwrdn_i = 1'b1;
    wait_fast(SelAckPwrdn, 1'b1, "ack_pwrdn_o to rise");
    req_pwrdn_i = 1'b0;
    if (timed_out) return;
    slow_cycles(1);
    compare_val("ast_o", 32'(ast_o), 32'(exp_lp));
    fast_cycles(1);
    compare_val("req_pwrup_o", 32'(req_pwrup_o), 32'd0);
  endtask

  // Short runs on enabled sources, free activity on masked ones
  task automatic glitch_window();
    int                  run [NumWkups];
    int                  rises;
    logic [NumWkups-1:0] drive;
    if (timed_out) return;
    foreach (run[i]) run[i] = 0;
    rises = req_rises;
    repeat (GlitchWindow) begin
      slow_cycles(1);
      for (int i = 0; i < NumWkups; i++) begin
        if (exp_en[i]) begin
          if (run[i] < FiltCycles - 2 && ($urandom % 2) == 1) begin
            drive[i] = 1'b1;
            run[i]++;
          end else begin
            drive[i] = 1'b0;
            run[i]   = 0;
          end
        end else begin
          drive[i] = 1'($urandom);
        end
      end
      wakeup_i = drive;
    end
    slow_cycles(1);
    wakeup_i = '0;
    // Filters drain before the next phase
    slow_cycles(4);
    fast_cycles(1);
    compare_val("req_pwrup_o rises", 32'(req_rises - rises), 32'd0);
  endtask

  task automatic wake_hold(input logic [NumWkups-1:0] held);
    if (timed_out) return;
    exp_status = held & exp_en;
    exp_cause  = Wakeup;
    slow_cycles(1);
    wakeup_i = held;
    slow_cycles(FiltCycles + 6);
    wakeup_i = '0;
    // Sources quiet before the channels are cleared
    slow_cycles(4);
  endtask

  task automatic request_pwrup();
    if (timed_out) return;
    fast_cycles(1);
    wait_fast(SelReqPwrup, 1'b1, "req_pwrup_o to rise");
    if (timed_out) return;
    compare_val("wake_status_o", 32'(wake_status_o), 32'(exp_status));
    compare_val("pwrup_cause_o", 32'(pwrup_cause_o), 32'(exp_cause));
  endtask

  task automatic ack_pwrup();
    if (timed_out) return;
    ack_pwrup_i = 1'b1;
    wait_fast(SelReqPwrup, 1'b0, "req_pwrup_o to fall");
    ack_pwrup_i = 1'b0;
    if (timed_out) return;
    slow_cycles(1);
    compare_val("ast_o", 32'(ast_o), 32'h7);
    // Synced ack must drop before the next power-down
    slow_cycles(4);
  endtask

  task automatic full_cycle();
    logic [NumWkups-1:0] en;
    logic [NumWkups-1:0] held;
    pwr_lp_cfg_t         lp;
    en   = rand_en();
    lp   = rand_lp();
    held = pick_held(en);
    write_config(en, lp);
    power_down();
    glitch_window();
    wake_hold(held);
    request_pwrup();
    ack_pwrup();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [NumWkups-1:0] held;
    void'($urandom(Seed));
    rst_slow_ni    = 1'b0;
    rst_fast_ni    = 1'b0;
    wakeup_i       = '0;
    wakeup_en_i    = '0;
    lp_cfg_i       = pwr_lp_cfg_default;
    cfg_cdc_sync_i = 1'b0;
    req_pwrdn_i    = 1'b0;
    ack_pwrup_i    = 1'b0;
    exp_en         = '0;
    exp_lp         = pwr_lp_cfg_default;
    exp_cause      = Por;
    exp_status     = '0;
    slow_cycles(16);
    rst_slow_ni = 1'b1;
    rst_fast_ni = 1'b1;

    start_test();
    slow_cycles(2);
    compare_val("ast_o", 32'(ast_o), 32'h7);
    fast_cycles(1);
    compare_val("ack_pwrdn_o", 32'(ack_pwrdn_o), 32'd0);
    compare_val("req_pwrup_o", 32'(req_pwrup_o), 32'd0);
    compare_val("cdc_sync_done_o", 32'(cdc_sync_done_o), 32'd0);
    compare_val("pwrup_cause_o", 32'(pwrup_cause_o), 32'(exp_cause));
    compare_val("wake_status_o", 32'(wake_status_o), 32'(exp_status));
    finish_test("reset_state");

    start_test();
    repeat (NumCfgWrites) write_config(rand_en(), rand_lp());
    finish_test("config_sync");

    // First power cycle, split into its checked phases
    start_test();
    write_config(rand_en(), rand_lp());
    power_down();
    finish_test("power_down");

    start_test();
    held = pick_held(exp_en);
    glitch_window();
    wake_hold(held);
    request_pwrup();
    finish_test("wakeup_filter");

    start_test();
    ack_pwrup();
    finish_test("ast_gating");

    start_test();
    repeat (NumCycles) full_cycle();
    finish_test("cause_transfer");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed, checks + gate_checks, total_errors());
    if (total_errors() == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
pwrmgr_pkg.sv
pwrmgr_pulse_sync.sv
pwrmgr_cdc.sv
pwrmgr_wake_chan.sv
pwrmgr_slow_fsm.sv
pwrmgr_top.sv
tb_pwrmgr.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the power manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_pwrmgr -f tb.f \
  && ./obj_dir/Vtb_pwrmgr > sim.log 2>&1
cat sim.log 2>/dev/null
# A missing log or a missing pass line also counts as failure
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
